// File: hdl/simon_pkg.sv
// Shared constants, color sequence table and packed types for the color memory game
package simon_pkg;

    // ----------------------------------------
    // Game constants
    // ----------------------------------------
    localparam int num_colors      = 4;
    localparam int color_w         = 2;
    localparam int max_rounds      = 16;
    localparam int short_rounds    = 8;
    localparam int round_w         = 4;
    localparam int show_on_cycles  = 8;
    localparam int show_off_cycles = 4;
    localparam int reply_timeout   = 64;
    localparam int timer_w         = 7;

    // Fixed color sequence, entry 0 is shown first
    localparam logic [color_w-1:0] color_sequence [max_rounds] = '{
        2'd0, 2'd2, 2'd1, 2'd3, 2'd2, 2'd0, 2'd3, 2'd1,
        2'd1, 2'd2, 2'd0, 2'd3, 2'd3, 2'd1, 2'd2, 2'd0
    };

    // ----------------------------------------
    // Shared types
    // ----------------------------------------
    typedef struct packed {
        logic               valid;
        logic [color_w-1:0] color;
    } press_t;

    // Controller strobes and levels toward the datapath
    typedef struct packed {
        logic clear_round;
        logic count_round;
        logic clear_step;
        logic count_step;
        logic clear_show;
        logic count_show;
        logic clear_reply;
        logic count_reply;
        logic store_press;
        logic lamps_show;
        logic lamps_echo;
        logic tone_on;
    } ctrl_t;

    typedef struct packed {
        logic show_done;
        logic gap_done;
        logic step_is_last;
        logic round_is_last;
        logic reply_expired;
        logic press_correct;
    } cond_t;

    typedef enum logic [4:0] {
        idle, init,
        round_start, show, show_wait, show_gap, show_next,
        reply_start, reply_wait, reply_pause,
        store, judge, next_step, next_round,
        won_state, lost_state, timeout_state
    } game_state_t;

endpackage

// File: hdl/button_conditioner.sv
// Button conditioner, synchronizes one raw button and pulses once per press
`timescale 1ns/1ns

module button_conditioner (
    input  logic clock,
    input  logic reset,
    input  logic raw,
    output logic pulse
);

    logic sync_meta;
    logic sync_stable;
    logic sync_prev;

    // Two-flop synchronizer plus the previous sample for edge detection
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            sync_meta   <= 1'b0;
            sync_stable <= 1'b0;
            sync_prev   <= 1'b0;
        end else begin
            sync_meta   <= raw;
            sync_stable <= sync_meta;
            sync_prev   <= sync_stable;
        end
    end

    // Rising edge only, a held button counts once
    assign pulse = sync_stable & ~sync_prev;

    a_pulse_single: assert property (@(posedge clock) disable iff (reset)
        pulse |=> !pulse);

endmodule

// File: hdl/press_encoder.sv
// Press encoder, folds four press pulses into one registered press event
`timescale 1ns/1ns

module press_encoder (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic [simon_pkg::num_colors-1:0]     pulses,
    output simon_pkg::press_t                    press
);

    logic [simon_pkg::color_w-1:0] code;

    // Lowest-numbered button wins when pulses coincide
    always_comb begin
        code = '0;
        for (int i = simon_pkg::num_colors - 1; i >= 0; i--) begin
            if (pulses[i]) code = simon_pkg::color_w'(i);
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            press.valid <= 1'b0;
            press.color <= '0;
        end else begin
            press.valid <= |pulses;
            // Color holds its last value between presses
            if (|pulses) press.color <= code;
        end
    end

    a_valid_follows: assert property (@(posedge clock) disable iff (reset)
        |pulses |=> press.valid);

endmodule

// File: hdl/game_datapath.sv
// Game datapath with step and round counters, timers, press register and comparator
`timescale 1ns/1ns

module game_datapath (
    input  logic                             clock,
    input  logic                             reset,
    input  simon_pkg::ctrl_t                 ctrl,
    input  simon_pkg::press_t                press,
    input  logic                             long_game,
    input  logic                             fast_level,
    output simon_pkg::cond_t                 cond,
    output logic [simon_pkg::num_colors-1:0] lamps,
    output logic                             tone
);

    logic [simon_pkg::round_w-1:0] step_count;
    logic [simon_pkg::round_w-1:0] round_count;
    logic [simon_pkg::timer_w-1:0] show_timer;
    logic [simon_pkg::timer_w-1:0] reply_timer;
    logic [simon_pkg::color_w-1:0] stored_color;
    logic                          long_latched;
    logic                          fast_latched;
    logic [simon_pkg::round_w-1:0] last_round;
    logic [simon_pkg::timer_w-1:0] reply_limit;
    logic [simon_pkg::color_w-1:0] shown_color;

    // ----------------------------------------
    // Counters and timers
    // ----------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            step_count  <= '0;
            round_count <= '0;
            show_timer  <= '0;
            reply_timer <= '0;
        end else begin
            if (ctrl.clear_step)       step_count <= '0;
            else if (ctrl.count_step)  step_count <= step_count + 1'b1;

            if (ctrl.clear_round)      round_count <= '0;
            else if (ctrl.count_round) round_count <= round_count + 1'b1;

            if (ctrl.clear_show)       show_timer <= '0;
            else if (ctrl.count_show)  show_timer <= show_timer + 1'b1;

            if (ctrl.clear_reply)      reply_timer <= '0;
            else if (ctrl.count_reply) reply_timer <= reply_timer + 1'b1;
        end
    end

    // Level choices are taken when the round counter clears at game start
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            long_latched <= 1'b0;
            fast_latched <= 1'b0;
        end else if (ctrl.clear_round) begin
            long_latched <= long_game;
            fast_latched <= fast_level;
        end
    end

    always_ff @(posedge clock) begin
        if (ctrl.store_press) stored_color <= press.color;
    end

    // ----------------------------------------
    // Conditions toward the controller
    // ----------------------------------------
    assign shown_color = simon_pkg::color_sequence[step_count];

    assign last_round = long_latched ? simon_pkg::round_w'(simon_pkg::max_rounds - 1)
                                     : simon_pkg::round_w'(simon_pkg::short_rounds - 1);

    // Fast level halves the reply wait
    assign reply_limit = fast_latched
        ? simon_pkg::timer_w'(simon_pkg::reply_timeout / 2 - 1)
        : simon_pkg::timer_w'(simon_pkg::reply_timeout - 1);

    always_comb begin
        cond.show_done     = (show_timer == simon_pkg::timer_w'(simon_pkg::show_on_cycles - 1));
        cond.gap_done      = (show_timer == simon_pkg::timer_w'(simon_pkg::show_off_cycles - 1));
        cond.step_is_last  = (step_count == round_count);
        cond.round_is_last = (round_count == last_round);
        cond.reply_expired = (reply_timer >= reply_limit);
        cond.press_correct = (stored_color == shown_color);
    end

    // ----------------------------------------
    // Lamps and tone
    // ----------------------------------------
    always_comb begin
        lamps = '0;
        if (ctrl.lamps_show) begin
            lamps[shown_color] = 1'b1;
        end else if (ctrl.lamps_echo) begin
            lamps[stored_color] = 1'b1;
        end
    end

    assign tone = ctrl.tone_on;

    a_one_lamp: assert property (@(posedge clock) disable iff (reset)
        $onehot0(lamps));

endmodule

// File: hdl/game_control.sv
// Moore game controller sequencing show, reply, pause and end states
`timescale 1ns/1ns

module game_control (
    input  logic              clock,
    input  logic              reset,
    input  logic              start,
    input  logic              pause,
    input  simon_pkg::press_t press,
    input  simon_pkg::cond_t  cond,
    output simon_pkg::ctrl_t  ctrl,
    output logic              player_turn,
    output logic              paused,
    output logic              won,
    output logic              lost,
    output logic              timed_out,
    output logic              ready
);

    simon_pkg::game_state_t state;
    simon_pkg::game_state_t state_next;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) state <= simon_pkg::idle;
        else       state <= state_next;
    end

    // ----------------------------------------
    // Next state
    // ----------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            simon_pkg::idle:        if (start) state_next = simon_pkg::init;
            simon_pkg::init:        state_next = simon_pkg::round_start;
            simon_pkg::round_start: if (cond.gap_done) state_next = simon_pkg::show;
            simon_pkg::show:        state_next = simon_pkg::show_wait;
            simon_pkg::show_wait: begin
                if (cond.show_done) begin
                    state_next = cond.step_is_last ? simon_pkg::reply_start
                                                   : simon_pkg::show_next;
                end
            end
            // Step advances first, then the dark gap runs from a cleared timer
            simon_pkg::show_next:   state_next = simon_pkg::show_gap;
            simon_pkg::show_gap:    if (cond.gap_done) state_next = simon_pkg::show;
            simon_pkg::reply_start: state_next = simon_pkg::reply_wait;
            simon_pkg::reply_wait: begin
                if (pause)                   state_next = simon_pkg::reply_pause;
                else if (cond.reply_expired) state_next = simon_pkg::timeout_state;
                else if (press.valid)        state_next = simon_pkg::store;
            end
            simon_pkg::reply_pause: if (!pause) state_next = simon_pkg::reply_wait;
            simon_pkg::store:       state_next = simon_pkg::judge;
            simon_pkg::judge: begin
                if (cond.gap_done) begin
                    if (!cond.press_correct)    state_next = simon_pkg::lost_state;
                    else if (!cond.step_is_last) state_next = simon_pkg::next_step;
                    else if (cond.round_is_last) state_next = simon_pkg::won_state;
                    else                         state_next = simon_pkg::next_round;
                end
            end
            simon_pkg::next_step:   state_next = simon_pkg::reply_wait;
            simon_pkg::next_round:  state_next = simon_pkg::round_start;
            simon_pkg::won_state,
            simon_pkg::lost_state,
            simon_pkg::timeout_state: if (start) state_next = simon_pkg::init;
            default:                state_next = simon_pkg::idle;
        endcase
    end

    // ----------------------------------------
    // Moore outputs
    // ----------------------------------------
    always_comb begin
        ctrl = '0;
        case (state)
            simon_pkg::init: begin
                ctrl.clear_round = 1'b1;
                ctrl.clear_step  = 1'b1;
                ctrl.clear_show  = 1'b1;
                ctrl.clear_reply = 1'b1;
            end
            simon_pkg::round_start: begin
                ctrl.clear_step = 1'b1;
                ctrl.count_show = 1'b1;
            end
            simon_pkg::show:        ctrl.clear_show = 1'b1;
            simon_pkg::show_wait: begin
                ctrl.count_show = 1'b1;
                ctrl.lamps_show = 1'b1;
                ctrl.tone_on    = 1'b1;
            end
            simon_pkg::show_next: begin
                ctrl.count_step = 1'b1;
                ctrl.clear_show = 1'b1;
            end
            simon_pkg::show_gap:    ctrl.count_show = 1'b1;
            simon_pkg::reply_start: begin
                ctrl.clear_step  = 1'b1;
                ctrl.clear_reply = 1'b1;
            end
            simon_pkg::reply_wait:  ctrl.count_reply = 1'b1;
            simon_pkg::store: begin
                ctrl.store_press = 1'b1;
                ctrl.clear_show  = 1'b1;
            end
            // Pressed lamp echoes with the tone while the reply settles
            simon_pkg::judge: begin
                ctrl.count_show = 1'b1;
                ctrl.lamps_echo = 1'b1;
                ctrl.tone_on    = 1'b1;
            end
            simon_pkg::next_step: begin
                ctrl.count_step  = 1'b1;
                ctrl.clear_reply = 1'b1;
            end
            simon_pkg::next_round: begin
                ctrl.count_round = 1'b1;
                ctrl.clear_show  = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

    assign player_turn = (state == simon_pkg::reply_wait);
    assign paused      = (state == simon_pkg::reply_pause);
    assign won         = (state == simon_pkg::won_state);
    assign timed_out   = (state == simon_pkg::timeout_state);
    assign lost        = (state == simon_pkg::lost_state) || timed_out;
    assign ready       = won || lost;

    a_not_both: assert property (@(posedge clock) disable iff (reset)
        !(won && lost));

    a_idle_quiet: assert property (@(posedge clock) disable iff (reset)
        (state == simon_pkg::idle) |-> (ctrl == '0));

endmodule

// File: hdl/simon_game.sv
// Color memory game top level joining button conditioning, datapath and controller
`timescale 1ns/1ns

module simon_game (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             start,
    input  logic                             pause,
    input  logic                             long_game,
    input  logic                             fast_level,
    input  logic [simon_pkg::num_colors-1:0] buttons,
    output logic [simon_pkg::num_colors-1:0] lamps,
    output logic                             tone,
    output logic                             player_turn,
    output logic                             paused,
    output logic                             won,
    output logic                             lost,
    output logic                             timed_out,
    output logic                             ready
);

    logic [simon_pkg::num_colors-1:0] pulses;
    simon_pkg::press_t                press;
    simon_pkg::ctrl_t                 ctrl;
    simon_pkg::cond_t                 cond;

    // ----------------------------------------
    // Button path
    // ----------------------------------------
    for (genvar i = 0; i < simon_pkg::num_colors; i++) begin : gen_buttons
        button_conditioner button_conditioner_inst (
            .clock (clock),
            .reset (reset),
            .raw   (buttons[i]),
            .pulse (pulses[i])
        );
    end

    press_encoder press_encoder_inst (
        .clock  (clock),
        .reset  (reset),
        .pulses (pulses),
        .press  (press)
    );

    // ----------------------------------------
    // Datapath and controller
    // ----------------------------------------
    game_datapath game_datapath_inst (
        .clock      (clock),
        .reset      (reset),
        .ctrl       (ctrl),
        .press      (press),
        .long_game  (long_game),
        .fast_level (fast_level),
        .cond       (cond),
        .lamps      (lamps),
        .tone       (tone)
    );

    game_control game_control_inst (
        .clock       (clock),
        .reset       (reset),
        .start       (start),
        .pause       (pause),
        .press       (press),
        .cond        (cond),
        .ctrl        (ctrl),
        .player_turn (player_turn),
        .paused      (paused),
        .won         (won),
        .lost        (lost),
        .timed_out   (timed_out),
        .ready       (ready)
    );

endmodule

// File: tb/simon_game_tb.sv
// Testbench for the color memory game, plays scripted games and checks them with assertions
`timescale 1ns/1ns

module simon_game_tb;

    logic                             clock;
    logic                             reset;
    logic                             start;
    logic                             pause;
    logic                             long_game;
    logic                             fast_level;
    logic [simon_pkg::num_colors-1:0] buttons;
    logic [simon_pkg::num_colors-1:0] lamps;
    logic                             tone;
    logic                             player_turn;
    logic                             paused;
    logic                             won;
    logic                             lost;
    logic                             timed_out;
    logic                             ready;

    // Reference model of the game progress
    logic [simon_pkg::num_colors-1:0] lamps_prev;
    logic                             turn_prev;
    logic                             showing;
    logic                             started;
    logic                             fast_game;
    logic [2:0]                       expect_outcome;
    logic [31:0]                      lfsr_state;
    logic [10:0]                      out_bits;
    int                               shown;
    int                               answered;
    int                               round_len;
    int                               rounds_played;
    int                               wait_cycles;
    int                               show_index;
    int                               pressed_color;
    int                               game_rounds;

    simon_game simon_game_inst (
        .clock       (clock),
        .reset       (reset),
        .start       (start),
        .pause       (pause),
        .long_game   (long_game),
        .fast_level  (fast_level),
        .buttons     (buttons),
        .lamps       (lamps),
        .tone        (tone),
        .player_turn (player_turn),
        .paused      (paused),
        .won         (won),
        .lost        (lost),
        .timed_out   (timed_out),
        .ready       (ready)
    );

    initial clock = 1'b0;
    always #4 clock = ~clock;

    assign out_bits   = {lamps, tone, player_turn, paused, won, lost, timed_out, ready};
    // Index of the lit show step, the count moves on one edge after the lamp rises
    assign show_index = (lamps_prev == '0) ? shown : shown - 1;

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic logic [simon_pkg::num_colors-1:0] color_lamp(input int color);
        return simon_pkg::num_colors'(1) << color;
    endfunction

    function automatic int sequence_color(input int index);
        return int'(simon_pkg::color_sequence[index[simon_pkg::round_w-1:0]]);
    endfunction

    task automatic draw_bits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic fail_value(input string name, input int expected, input int seen);
        $display("CHECK FAILED at time %0t: %s expected %0d, seen %0d",
                 $time, name, expected, seen);
        $display("=== FAIL ===");
        $fatal(1, "value check failed");
    endtask

    task automatic wait_for_turn();
        @(negedge clock);
        while (!player_turn) @(negedge clock);
    endtask

    task automatic wait_for_ready();
        @(negedge clock);
        while (!ready) @(negedge clock);
    endtask

    // Random idle delay and hold length, then wait until the reply is taken
    task automatic press_button(input int color);
        int delay;
        int hold;
        draw_bits(3, delay);
        draw_bits(2, hold);
        repeat (delay) @(posedge clock);
        @(posedge clock);
        pressed_color = color;
        buttons <= color_lamp(color);
        repeat (hold + 1) @(posedge clock);
        buttons <= '0;
        @(negedge clock);
        while (player_turn) @(negedge clock);
    endtask

    task automatic hold_pause();
        @(posedge clock);
        pause <= 1'b1;
        repeat (simon_pkg::reply_timeout + 12) @(posedge clock);
        pause <= 1'b0;
    endtask

    task automatic play_game(input bit long_sel, input bit fast_sel, input bit wrong_press,
                             input bit go_silent, input int end_round, input int end_step,
                             input int pause_round);
        int  rounds;
        int  color;
        bit  done;
        rounds = long_sel ? simon_pkg::max_rounds : simon_pkg::short_rounds;
        done = 1'b0;
        game_rounds = rounds;
        fast_game = fast_sel;
        // Expected {won, lost, timed_out}
        expect_outcome = wrong_press ? 3'b010 : (go_silent ? 3'b011 : 3'b100);
        @(posedge clock);
        long_game <= long_sel;
        fast_level <= fast_sel;
        start <= 1'b1;
        started = 1'b1;
        @(posedge clock);
        start <= 1'b0;
        for (int r = 0; r < rounds && !done; r++) begin
            for (int k = 0; k <= r && !done; k++) begin
                wait_for_turn();
                if (r == pause_round && k == 0) begin
                    hold_pause();
                    wait_for_turn();
                end
                if (go_silent && r == end_round && k == end_step) begin
                    done = 1'b1;
                end else begin
                    color = sequence_color(k);
                    if (wrong_press && r == end_round && k == end_step) begin
                        color = (color + 1) % simon_pkg::num_colors;
                        done = 1'b1;
                    end
                    press_button(color);
                end
            end
        end
        wait_for_ready();
        repeat (6) @(posedge clock);
    endtask

    // ----------------------------------------
    // Game progress model
    // ----------------------------------------
    always @(posedge clock or posedge reset) begin
        if (reset) begin
            lamps_prev    <= '0;
            turn_prev     <= 1'b0;
            showing       <= 1'b1;
            shown         <= 0;
            answered      <= 0;
            round_len     <= 1;
            rounds_played <= 0;
            wait_cycles   <= 0;
        end else begin
            lamps_prev <= lamps;
            turn_prev  <= player_turn;
            if (player_turn && !turn_prev) wait_cycles <= 1;
            else if (player_turn)          wait_cycles <= wait_cycles + 1;
            if (start) begin
                showing       <= 1'b1;
                shown         <= 0;
                answered      <= 0;
                round_len     <= 1;
                rounds_played <= 0;
            end else if (showing) begin
                if (lamps != '0 && lamps_prev == '0) shown <= shown + 1;
                if (player_turn && !turn_prev) begin
                    showing       <= 1'b0;
                    rounds_played <= rounds_played + 1;
                end
            end else begin
                // Echo lamps in the reply phase, the last echo closes the round
                if (lamps != '0 && lamps_prev == '0) answered <= answered + 1;
                if (lamps == '0 && lamps_prev != '0 && answered == round_len) begin
                    showing   <= 1'b1;
                    shown     <= 0;
                    answered  <= 0;
                    round_len <= round_len + 1;
                end
            end
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    a_quiet_before_start: assert property (@(posedge clock) disable iff (reset)
        !started |-> out_bits == '0)
        else fail_value("outputs", 0, int'($sampled(out_bits)));

    a_show_count: assert property (@(posedge clock) disable iff (reset)
        showing && lamps != '0 |-> show_index < round_len)
        else fail_value("shown steps", $sampled(round_len), $sampled(show_index) + 1);

    a_show_order: assert property (@(posedge clock) disable iff (reset)
        showing && lamps != '0 && show_index < round_len
        |-> lamps == color_lamp(sequence_color(show_index)))
        else fail_value("lamps", int'(color_lamp(sequence_color($sampled(show_index)))),
                        int'($sampled(lamps)));

    a_turn_after_show: assert property (@(posedge clock) disable iff (reset)
        showing && player_turn |-> shown == round_len)
        else fail_value("shown steps", $sampled(round_len), $sampled(shown));

    a_echo: assert property (@(posedge clock) disable iff (reset)
        !showing && lamps != '0 |-> lamps == color_lamp(pressed_color))
        else fail_value("lamps", int'(color_lamp($sampled(pressed_color))),
                        int'($sampled(lamps)));

    // Tone sounds with every lit lamp and only then
    a_tone: assert property (@(posedge clock) disable iff (reset)
        tone == (lamps != '0))
        else fail_value("tone", int'($sampled(lamps) != '0), int'($sampled(tone)));

    a_outcome: assert property (@(posedge clock) disable iff (reset)
        $rose(ready) |-> {won, lost, timed_out} == expect_outcome)
        else fail_value("won lost timed_out", int'($sampled(expect_outcome)),
                        int'($sampled({won, lost, timed_out})));

    a_rounds_won: assert property (@(posedge clock) disable iff (reset)
        $rose(won) |-> rounds_played == game_rounds)
        else fail_value("rounds", $sampled(game_rounds), $sampled(rounds_played));

    a_end_quiet: assert property (@(posedge clock) disable iff (reset)
        ready |-> {lamps, player_turn} == '0)
        else fail_value("lamps and player_turn", 0, int'($sampled({lamps, player_turn})));

    a_end_held: assert property (@(posedge clock) disable iff (reset)
        $fell(ready) |-> $past(start))
        else fail_value("ready", 1, 0);

    a_fast_timeout: assert property (@(posedge clock) disable iff (reset)
        $rose(timed_out) && fast_game |-> wait_cycles <= simon_pkg::reply_timeout / 2 + 4)
        else fail_value("reply wait cycles", simon_pkg::reply_timeout / 2,
                        $sampled(wait_cycles));

    a_normal_timeout: assert property (@(posedge clock) disable iff (reset)
        $rose(timed_out) && !fast_game |-> wait_cycles >= simon_pkg::reply_timeout)
        else fail_value("reply wait cycles", simon_pkg::reply_timeout,
                        $sampled(wait_cycles));

    a_pause: assert property (@(posedge clock) disable iff (reset)
        pause && $past(pause) |-> paused && !player_turn)
        else fail_value("paused and player_turn", 2,
                        int'($sampled({paused, player_turn})));

    // ----------------------------------------
    // Stimulus and watchdog
    // ----------------------------------------
    initial begin : watchdog
        int limit_cycles;
        limit_cycles = 2 * (4 * simon_pkg::short_rounds * simon_pkg::short_rounds
                       + simon_pkg::max_rounds * simon_pkg::max_rounds)
                       * (simon_pkg::show_on_cycles + simon_pkg::show_off_cycles
                       + simon_pkg::reply_timeout);
        repeat (limit_cycles) @(posedge clock);
        $display("Watchdog expired, the games did not end within %0d clock cycles",
                 limit_cycles);
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

    initial begin : stimulus
        int bad_round;
        int bad_draw;
        lfsr_state     = 32'h4b72_461c;
        started        = 1'b0;
        fast_game      = 1'b0;
        expect_outcome = 3'b000;
        pressed_color  = 0;
        game_rounds    = 0;
        reset          = 1'b1;
        start          = 1'b0;
        pause          = 1'b0;
        long_game      = 1'b0;
        fast_level     = 1'b0;
        buttons        = '0;
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        repeat (4) @(posedge clock);

        // Short and long games won, the long one with a pause past the timeout
        play_game(1'b0, 1'b0, 1'b0, 1'b0, -1, -1, -1);
        play_game(1'b1, 1'b0, 1'b0, 1'b0, -1, -1, 2);

        // Wrong button at a random step
        draw_bits(3, bad_round);
        draw_bits(4, bad_draw);
        play_game(1'b0, 1'b0, 1'b1, 1'b0, bad_round, bad_draw % (bad_round + 1), -1);

        // Silent player, fast then normal level
        play_game(1'b0, 1'b1, 1'b0, 1'b1, 2, 1, -1);
        play_game(1'b0, 1'b0, 1'b0, 1'b1, 0, 0, -1);

        repeat (4) @(posedge clock);
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: simon_game.f
hdl/simon_pkg.sv
hdl/button_conditioner.sv
hdl/press_encoder.sv
hdl/game_datapath.sv
hdl/game_control.sv
hdl/simon_game.sv
tb/simon_game_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the color memory game testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f simon_game.f --top-module simon_game_tb -o simon_game_sim

./obj_dir/simon_game_sim
